//--- boids_settings.svh
`ifndef BOIDS_SETTINGS_SVH
`define BOIDS_SETTINGS_SVH

////////////////////
// Frame geometry
////////////////////

// Boids handled per frame
`define BOIDS_NUM_BOIDS 20

// Onchip RAM port
`define BOIDS_ADDR_W 10
`define BOIDS_WORD_W 32

// Signed 12.15 fixed point
`define BOIDS_ATTR_W 27
`define BOIDS_FRAC_W 15

// Word 0 is the host flag, boid i slot s sits at base + 4i + s
`define BOIDS_FLAG_ADDR 0
`define BOIDS_BASE_ADDR 1

// Wall positions in whole pixels, same for both axes
`define BOIDS_BOUND_LO 0
`define BOIDS_BOUND_HI 639

// Address issue to read data capture
`define BOIDS_READ_WAIT 2

`endif

//--- boids_mem_pkg.sv
`default_nettype none

`include "boids_settings.svh"

package boids_mem_pkg;

	////////////////////
	// RAM side types
	////////////////////

	// Word address on the onchip RAM slave
	typedef logic [`BOIDS_ADDR_W-1:0] mem_addr_t;

	// One RAM data word
	typedef logic [`BOIDS_WORD_W-1:0] mem_word_t;

	// Position of an attribute inside the four word boid block
	typedef enum logic [1:0] {
		slot_x  = 2'd0,
		slot_y  = 2'd1,
		slot_vx = 2'd2,
		slot_vy = 2'd3
	} attr_slot_t;

endpackage

`default_nettype wire

//--- boids_state_pkg.sv
`default_nettype none

`include "boids_settings.svh"

package boids_state_pkg;

	////////////////////
	// Boid side types
	////////////////////

	// Signed fixed point coordinate or velocity
	typedef logic signed [`BOIDS_ATTR_W-1:0] coord_t;

	// Full boid record, 108 bits
	typedef struct packed {
		coord_t pos_x;
		coord_t pos_y;
		coord_t vel_x;
		coord_t vel_y;
	} boid_t;

	// Index into the local boid store
	typedef logic [$clog2(`BOIDS_NUM_BOIDS)-1:0] boid_idx_t;

endpackage

`default_nettype wire

//--- boid_store.sv
`timescale 1ns/1ns
`default_nettype none

`include "boids_settings.svh"

module boid_store (
	input  logic                       CLOCK_50,
	input  logic                       seq_wr_en,
	input  boids_state_pkg::boid_idx_t seq_idx,
	input  boids_state_pkg::boid_t     seq_wr_boid,
	input  logic                       step_wr_en,
	input  boids_state_pkg::boid_idx_t step_idx,
	input  boids_state_pkg::boid_t     step_wr_boid,
	output boids_state_pkg::boid_t     seq_rd_boid,
	output boids_state_pkg::boid_t     step_rd_boid
);

	////////////////////
	// Boid array
	////////////////////

	boids_state_pkg::boid_t boid_mem [`BOIDS_NUM_BOIDS];

	// Writes from either side, never both in the same cycle
	always_ff @(posedge CLOCK_50) begin
		if (seq_wr_en) begin
			boid_mem[seq_idx] <= seq_wr_boid;
		end
		if (step_wr_en) begin
			boid_mem[step_idx] <= step_wr_boid;
		end
	end

	// Registered reads, one per port
	always_ff @(posedge CLOCK_50) begin
		seq_rd_boid  <= boid_mem[seq_idx];
		step_rd_boid <= boid_mem[step_idx];
	end

	// Sequencer and stepper take turns on the store
	a_one_writer: assert property (@(posedge CLOCK_50)
		!(seq_wr_en && step_wr_en))
		else $error("sequencer and stepper write the store together");

endmodule

`default_nettype wire

//--- boid_motion_step.sv
`timescale 1ns/1ns
`default_nettype none

`include "boids_settings.svh"

module boid_motion_step (
	input  logic                       CLOCK_50,
	input  logic                       sys_reset,
	input  logic                       step_start,
	input  boids_state_pkg::boid_t     step_rd_boid,
	output logic                       step_done,
	output logic                       step_wr_en,
	output boids_state_pkg::boid_idx_t step_idx,
	output boids_state_pkg::boid_t     step_wr_boid
);

	typedef enum logic [1:0] {
		S_IDLE,
		S_READ,
		S_CALC,
		S_WRITE
	} step_state_t;

	// Walls in 12.15 fixed point
	localparam int BOUND_LO = `BOIDS_BOUND_LO <<< `BOIDS_FRAC_W;
	localparam int BOUND_HI = `BOIDS_BOUND_HI <<< `BOIDS_FRAC_W;
	localparam boids_state_pkg::boid_idx_t LAST_IDX =
		boids_state_pkg::boid_idx_t'(`BOIDS_NUM_BOIDS - 1);

	step_state_t            state;
	boids_state_pkg::boid_t next_boid;

	// One axis of the move, clamp and bounce off a wall
	function automatic void axis_step(
		input  boids_state_pkg::coord_t pos,
		input  boids_state_pkg::coord_t vel,
		output boids_state_pkg::coord_t pos_n,
		output boids_state_pkg::coord_t vel_n
	);
		logic signed [`BOIDS_ATTR_W:0] sum;
		sum = pos + vel;
		if (sum > BOUND_HI) begin
			pos_n = boids_state_pkg::coord_t'(BOUND_HI);
			vel_n = -vel;
		end else if (sum < BOUND_LO) begin
			pos_n = boids_state_pkg::coord_t'(BOUND_LO);
			vel_n = -vel;
		end else begin
			pos_n = sum[`BOIDS_ATTR_W-1:0];
			vel_n = vel;
		end
	endfunction

	always_comb begin
		axis_step(step_rd_boid.pos_x, step_rd_boid.vel_x, next_boid.pos_x, next_boid.vel_x);
		axis_step(step_rd_boid.pos_y, step_rd_boid.vel_y, next_boid.pos_y, next_boid.vel_y);
	end

	////////////////////
	// Walk FSM
	////////////////////

	always_ff @(posedge CLOCK_50) begin
		if (sys_reset) begin
			state      <= S_IDLE;
			step_idx   <= '0;
			step_wr_en <= 1'b0;
			step_done  <= 1'b0;
		end else begin
			step_wr_en <= 1'b0;
			step_done  <= 1'b0;
			case (state)
				S_IDLE: begin
					// Store already reads index 0, so this cycle is the first read
					if (step_start) begin
						state <= S_CALC;
					end
				end
				S_READ: state <= S_CALC;
				S_CALC: begin
					step_wr_en <= 1'b1;
					state      <= S_WRITE;
				end
				S_WRITE: begin
					if (step_idx == LAST_IDX) begin
						step_done <= 1'b1;
						step_idx  <= '0;
						state     <= S_IDLE;
					end else begin
						step_idx <= step_idx + 1'b1;
						state    <= S_READ;
					end
				end
				default: state <= S_IDLE;
			endcase
		end
	end

	// Updated record held for the write cycle
	always_ff @(posedge CLOCK_50) begin
		if (state == S_CALC) begin
			step_wr_boid <= next_boid;
		end
	end

	// Sequencer waits for step_done before any new start
	a_start_when_idle: assert property (@(posedge CLOCK_50) disable iff (sys_reset)
		step_start |-> state == S_IDLE)
		else $error("step_start while the stepper is busy");

endmodule

`default_nettype wire

//--- boid_frame_sequencer.sv
`timescale 1ns/1ns
`default_nettype none

`include "boids_settings.svh"

module boid_frame_sequencer (
	input  logic                       CLOCK_50,
	input  logic                       sys_reset,
	input  boids_mem_pkg::mem_word_t   mem_readdata,
	input  logic                       step_done,
	input  boids_state_pkg::boid_t     seq_rd_boid,
	output boids_mem_pkg::mem_addr_t   mem_address,
	output logic                       mem_write,
	output boids_mem_pkg::mem_word_t   mem_writedata,
	output logic                       step_start,
	output logic                       seq_wr_en,
	output boids_state_pkg::boid_idx_t seq_idx,
	output boids_state_pkg::boid_t     seq_wr_boid
);

	typedef enum logic [3:0] {
		S_POLL_ISSUE,
		S_POLL_WAIT,
		S_LOAD_ISSUE,
		S_LOAD_WAIT,
		S_START,
		S_STEP_WAIT,
		S_WB_READ,
		S_WB_WORD,
		S_FLAG_CLR
	} seq_state_t;

	localparam boids_mem_pkg::mem_addr_t FLAG_ADDR =
		boids_mem_pkg::mem_addr_t'(`BOIDS_FLAG_ADDR);
	localparam boids_mem_pkg::mem_addr_t BASE_ADDR =
		boids_mem_pkg::mem_addr_t'(`BOIDS_BASE_ADDR);
	localparam boids_state_pkg::boid_idx_t LAST_IDX =
		boids_state_pkg::boid_idx_t'(`BOIDS_NUM_BOIDS - 1);
	localparam logic [1:0] LAST_WAIT = 2'(`BOIDS_READ_WAIT - 1);

	seq_state_t                 state;
	boids_mem_pkg::attr_slot_t  slot;
	logic [1:0]                 wait_cnt;
	boids_state_pkg::boid_idx_t next_idx;
	boids_mem_pkg::mem_addr_t   slot_addr;
	boids_state_pkg::coord_t    rd_attr;
	boids_state_pkg::coord_t    wb_attr;

	// Record written last cycle moves the load on to the next boid
	assign next_idx  = seq_wr_en ? seq_idx + 1'b1 : seq_idx;
	assign slot_addr = BASE_ADDR + boids_mem_pkg::mem_addr_t'({next_idx, slot});
	assign rd_attr   = mem_readdata[`BOIDS_ATTR_W-1:0];

	// Attribute picked for the current write-back word
	always_comb begin
		case (slot)
			boids_mem_pkg::slot_x:  wb_attr = seq_rd_boid.pos_x;
			boids_mem_pkg::slot_y:  wb_attr = seq_rd_boid.pos_y;
			boids_mem_pkg::slot_vx: wb_attr = seq_rd_boid.vel_x;
			default:                wb_attr = seq_rd_boid.vel_y;
		endcase
	end

	////////////////////
	// Control FSM
	////////////////////

	always_ff @(posedge CLOCK_50) begin
		if (sys_reset) begin
			state       <= S_POLL_ISSUE;
			mem_address <= FLAG_ADDR;
			mem_write   <= 1'b0;
			step_start  <= 1'b0;
			seq_wr_en   <= 1'b0;
			seq_idx     <= '0;
			slot        <= boids_mem_pkg::slot_x;
			wait_cnt    <= '0;
		end else begin
			mem_write  <= 1'b0;
			step_start <= 1'b0;
			seq_wr_en  <= 1'b0;
			case (state)
				S_POLL_ISSUE: begin
					mem_address <= FLAG_ADDR;
					wait_cnt    <= '0;
					state       <= S_POLL_WAIT;
				end
				S_POLL_WAIT: begin
					wait_cnt <= wait_cnt + 1'b1;
					if (wait_cnt == LAST_WAIT) begin
						// Host raises bit 0 to hand over a frame
						state <= mem_readdata[0] ? S_LOAD_ISSUE : S_POLL_ISSUE;
					end
				end
				S_LOAD_ISSUE: begin
					mem_address <= slot_addr;
					seq_idx     <= next_idx;
					wait_cnt    <= '0;
					state       <= S_LOAD_WAIT;
				end
				S_LOAD_WAIT: begin
					wait_cnt <= wait_cnt + 1'b1;
					if (wait_cnt == LAST_WAIT) begin
						slot <= boids_mem_pkg::attr_slot_t'(slot + 2'd1);
						if (slot == boids_mem_pkg::slot_vy) begin
							seq_wr_en <= 1'b1;
							state     <= (seq_idx == LAST_IDX) ? S_START : S_LOAD_ISSUE;
						end else begin
							state <= S_LOAD_ISSUE;
						end
					end
				end
				S_START: begin
					// Last record lands in the store on this edge
					step_start <= 1'b1;
					seq_idx    <= '0;
					state      <= S_STEP_WAIT;
				end
				S_STEP_WAIT: begin
					if (step_done) begin
						state <= S_WB_READ;
					end
				end
				S_WB_READ: begin
					state <= S_WB_WORD;
				end
				S_WB_WORD: begin
					mem_write   <= 1'b1;
					mem_address <= slot_addr;
					slot        <= boids_mem_pkg::attr_slot_t'(slot + 2'd1);
					if (slot == boids_mem_pkg::slot_vy) begin
						if (seq_idx == LAST_IDX) begin
							state <= S_FLAG_CLR;
						end else begin
							seq_idx <= seq_idx + 1'b1;
							state   <= S_WB_READ;
						end
					end
				end
				S_FLAG_CLR: begin
					mem_write   <= 1'b1;
					mem_address <= FLAG_ADDR;
					seq_idx     <= '0;
					state       <= S_POLL_ISSUE;
				end
				default: state <= S_POLL_ISSUE;
			endcase
		end
	end

	// Record assembly and outgoing words
	always_ff @(posedge CLOCK_50) begin
		if (state == S_LOAD_WAIT && wait_cnt == LAST_WAIT) begin
			case (slot)
				boids_mem_pkg::slot_x:  seq_wr_boid.pos_x <= rd_attr;
				boids_mem_pkg::slot_y:  seq_wr_boid.pos_y <= rd_attr;
				boids_mem_pkg::slot_vx: seq_wr_boid.vel_x <= rd_attr;
				default:                seq_wr_boid.vel_y <= rd_attr;
			endcase
		end
		if (state == S_WB_WORD) begin
			// Sign extend to the full bus word
			mem_writedata <= {{(`BOIDS_WORD_W - `BOIDS_ATTR_W){wb_attr[`BOIDS_ATTR_W-1]}},
				wb_attr};
		end else if (state == S_FLAG_CLR) begin
			mem_writedata <= '0;
		end
	end

	// Bus stays read-only from the poll until the frame is stepped
	a_no_write_in_load: assert property (@(posedge CLOCK_50) disable iff (sys_reset)
		state inside {S_POLL_WAIT, S_LOAD_ISSUE, S_LOAD_WAIT} |-> !mem_write)
		else $error("mem_write high during poll or load");

endmodule

`default_nettype wire

//--- boids_engine_top.sv
`timescale 1ns/1ns
`default_nettype none

module boids_engine_top (
	input  logic                     CLOCK_50,
	input  logic                     sys_reset,
	input  boids_mem_pkg::mem_word_t mem_readdata,
	output boids_mem_pkg::mem_addr_t mem_address,
	output logic                     mem_write,
	output boids_mem_pkg::mem_word_t mem_writedata
);

	// Sequencer side of the store
	logic                       seq_wr_en;
	boids_state_pkg::boid_idx_t seq_idx;
	boids_state_pkg::boid_t     seq_wr_boid;
	boids_state_pkg::boid_t     seq_rd_boid;

	// Stepper side of the store
	logic                       step_wr_en;
	boids_state_pkg::boid_idx_t step_idx;
	boids_state_pkg::boid_t     step_wr_boid;
	boids_state_pkg::boid_t     step_rd_boid;

	logic step_start;
	logic step_done;

	boid_frame_sequencer u_sequencer (
		.CLOCK_50      (CLOCK_50),
		.sys_reset     (sys_reset),
		.mem_readdata  (mem_readdata),
		.step_done     (step_done),
		.seq_rd_boid   (seq_rd_boid),
		.mem_address   (mem_address),
		.mem_write     (mem_write),
		.mem_writedata (mem_writedata),
		.step_start    (step_start),
		.seq_wr_en     (seq_wr_en),
		.seq_idx       (seq_idx),
		.seq_wr_boid   (seq_wr_boid)
	);

	boid_store u_store (
		.CLOCK_50     (CLOCK_50),
		.seq_wr_en    (seq_wr_en),
		.seq_idx      (seq_idx),
		.seq_wr_boid  (seq_wr_boid),
		.step_wr_en   (step_wr_en),
		.step_idx     (step_idx),
		.step_wr_boid (step_wr_boid),
		.seq_rd_boid  (seq_rd_boid),
		.step_rd_boid (step_rd_boid)
	);

	boid_motion_step u_stepper (
		.CLOCK_50     (CLOCK_50),
		.sys_reset    (sys_reset),
		.step_start   (step_start),
		.step_rd_boid (step_rd_boid),
		.step_done    (step_done),
		.step_wr_en   (step_wr_en),
		.step_idx     (step_idx),
		.step_wr_boid (step_wr_boid)
	);

endmodule

`default_nettype wire

//--- tb_onchip_ram.sv
`timescale 1ns/1ns
`default_nettype none

`include "boids_settings.svh"

module tb_onchip_ram (
	input  logic                     CLOCK_50,
	input  boids_mem_pkg::mem_addr_t address,
	input  logic                     write,
	input  boids_mem_pkg::mem_word_t writedata,
	output boids_mem_pkg::mem_word_t readdata
);

	localparam int DEPTH = 1 << `BOIDS_ADDR_W;

	boids_mem_pkg::mem_word_t ram_words [DEPTH];

	// Fill built from the whole address, so stray reads stand out
	initial begin
		int n;
		logic [`BOIDS_ADDR_W-1:0] a;
		for (n = 0; n < DEPTH; n++) begin
			a = n[`BOIDS_ADDR_W-1:0];
			ram_words[n] <= {a, 6'h15, a, 6'h2A};
		end
		readdata <= '0;
	end

	////////////////////
	// Slave port
	////////////////////

	// Read data is registered, one cycle after the address
	always @(posedge CLOCK_50) begin
		if (write) begin
			ram_words[address] <= writedata;
		end
		readdata <= ram_words[address];
	end

	////////////////////
	// Backdoor access
	////////////////////

	task automatic poke_word(input boids_mem_pkg::mem_addr_t addr,
		input boids_mem_pkg::mem_word_t data);
		ram_words[addr] <= data;
	endtask

	task automatic peek_word(input boids_mem_pkg::mem_addr_t addr,
		output boids_mem_pkg::mem_word_t data);
		data = ram_words[addr];
	endtask

endmodule

`default_nettype wire

//--- boids_engine_tb.sv
`timescale 1ns/1ns
`default_nettype none

`include "boids_settings.svh"

module boids_engine_tb;

	localparam int CLK_PERIOD   = 100;
	localparam int DRIVE_DELAY  = 1;
	localparam int RESET_CYCLES = 10;
	localparam int IDLE_CYCLES  = 300;
	localparam int QUIET_CYCLES = 50;
	localparam int NUM_TESTS    = 4;
	localparam int NB           = `BOIDS_NUM_BOIDS;
	localparam int FRAME_CYCLES = NB * NB + 100;
	localparam int WATCHDOG_NS  =
		(RESET_CYCLES + IDLE_CYCLES + NUM_TESTS * (FRAME_CYCLES + QUIET_CYCLES)) * CLK_PERIOD;

	// Fixed point scale and walls
	localparam int ONE       = 1 <<< `BOIDS_FRAC_W;
	localparam int WALL_LO   = `BOIDS_BOUND_LO * ONE;
	localparam int WALL_HI   = `BOIDS_BOUND_HI * ONE;
	localparam int MARGIN    = 8 * ONE;
	localparam int VEL_MAX   = 8 * ONE;
	localparam int ATTR_MASK = (1 << `BOIDS_ATTR_W) - 1;
	localparam boids_mem_pkg::mem_addr_t FLAG = boids_mem_pkg::mem_addr_t'(`BOIDS_FLAG_ADDR);

	logic                     CLOCK_50;
	logic                     sys_reset;
	boids_mem_pkg::mem_word_t mem_readdata;
	boids_mem_pkg::mem_addr_t mem_address;
	logic                     mem_write;
	boids_mem_pkg::mem_word_t mem_writedata;

	// Test table, attributes in slot order x, y, vx, vy
	string       test_name   [NUM_TESTS];
	logic [31:0] test_flag   [NUM_TESTS];
	bit          test_reload [NUM_TESTS];
	int          stim        [NUM_TESTS][NB][4];
	int          expect_v    [NUM_TESTS][NB][4];
	int          seed;

	boids_engine_top boids_engine_top_i (
		.CLOCK_50      (CLOCK_50),
		.sys_reset     (sys_reset),
		.mem_readdata  (mem_readdata),
		.mem_address   (mem_address),
		.mem_write     (mem_write),
		.mem_writedata (mem_writedata)
	);

	tb_onchip_ram ram_i (
		.CLOCK_50  (CLOCK_50),
		.address   (mem_address),
		.write     (mem_write),
		.writedata (mem_writedata),
		.readdata  (mem_readdata)
	);

	initial begin
		CLOCK_50 = 1'b0;
		forever #(CLK_PERIOD / 2) CLOCK_50 = ~CLOCK_50;
	end

	initial begin
		#(WATCHDOG_NS);
		abort_run($sformatf("Timeout after %0d ns, the frame never finished", WATCHDOG_NS));
	end

	task automatic abort_run(input string line);
		$display("%s", line);
		$display("SOME TESTS FAILED");
		$fatal(1, "run stopped at the first error");
	endtask

	function automatic string slot_label(input int s);
		case (s)
			0:       return "x";
			1:       return "y";
			2:       return "vx";
			default: return "vy";
		endcase
	endfunction

	function automatic boids_mem_pkg::mem_addr_t word_addr(input int i, input int s);
		return boids_mem_pkg::mem_addr_t'(`BOIDS_BASE_ADDR + 4 * i + s);
	endfunction

	////////////////////
	// Reference model
	////////////////////

	// Move one axis, stop at a wall and turn back
	function automatic void bounce_axis(input int pos, input int vel,
		output int pos_n, output int vel_n);
		int sum;
		sum = pos + vel;
		if (sum > WALL_HI) begin
			pos_n = WALL_HI;
			vel_n = -vel;
		end else if (sum < WALL_LO) begin
			pos_n = WALL_LO;
			vel_n = -vel;
		end else begin
			pos_n = sum;
			vel_n = vel;
		end
	endfunction

	function automatic void compute_expected(input int t);
		int i;
		for (i = 0; i < NB; i++) begin
			bounce_axis(stim[t][i][0], stim[t][i][2], expect_v[t][i][0], expect_v[t][i][2]);
			bounce_axis(stim[t][i][1], stim[t][i][3], expect_v[t][i][1], expect_v[t][i][3]);
		end
	endfunction

	////////////////////
	// Table setup
	////////////////////

	function automatic int random_pos();
		int r;
		r = $random(seed);
		return MARGIN + int'((r & 32'h7FFF_FFFF) % (WALL_HI - 2 * MARGIN + 1));
	endfunction

	function automatic int random_vel();
		int r;
		r = $random(seed);
		return int'((r & 32'h7FFF_FFFF) % (2 * VEL_MAX + 1)) - VEL_MAX;
	endfunction

	function automatic void set_boid(input int t, input int i,
		input real x, input real y, input real vx, input real vy);
		stim[t][i][0] = int'(x * ONE);
		stim[t][i][1] = int'(y * ONE);
		stim[t][i][2] = int'(vx * ONE);
		stim[t][i][3] = int'(vy * ONE);
	endfunction

	function automatic void fill_random(input int t);
		int i;
		for (i = 0; i < NB; i++) begin
			stim[t][i][0] = random_pos();
			stim[t][i][1] = random_pos();
			stim[t][i][2] = random_vel();
			stim[t][i][3] = random_vel();
		end
	endfunction

	function automatic void build_table();
		int i;
		int s;
		test_name[0] = "free_motion";
		test_flag[0] = 32'h0000_0001;
		test_reload[0] = 1'b1;
		fill_random(0);
		test_name[1] = "high_wall";
		test_flag[1] = 32'h0000_0001;
		test_reload[1] = 1'b1;
		fill_random(1);
		set_boid(1, 0, 638.5, 320.0, 2.0, 0.5);
		set_boid(1, 1, 100.0, 637.0, -1.0, 3.25);
		set_boid(1, 2, 639.0, 639.0, 0.0, 0.0);
		set_boid(1, 3, 636.0, 633.0, 8.0, 8.0);
		set_boid(1, 4, 631.0, 200.0, 7.75, -2.0);
		// Only bit 0 of the flag should matter
		test_name[2] = "low_wall";
		test_flag[2] = 32'h8000_0001;
		test_reload[2] = 1'b1;
		fill_random(2);
		set_boid(2, 0, 0.5, 50.0, -1.0, 0.0);
		set_boid(2, 1, 300.0, 0.0, 1.5, -8.0);
		set_boid(2, 2, 3.0, 10.0, -3.0, -0.25);
		set_boid(2, 3, 2.0, 1.0, -4.0, -7.5);
		set_boid(2, 4, 5.0, 5.0, -0.25, -0.125);
		for (i = 0; i < 3; i++) begin
			compute_expected(i);
		end
		// Second frame runs on what the engine wrote back
		test_name[3] = "second_frame";
		test_flag[3] = 32'h0000_0003;
		test_reload[3] = 1'b0;
		for (i = 0; i < NB; i++) begin
			for (s = 0; s < 4; s++) begin
				stim[3][i][s] = expect_v[2][i][s];
			end
		end
		compute_expected(3);
	endfunction

	////////////////////
	// Test steps
	////////////////////

	task automatic check_idle();
		repeat (IDLE_CYCLES) begin
			@(negedge CLOCK_50);
			assert (!mem_write) else abort_run($sformatf(
				"MISMATCH test=idle mem_write expected=0 actual=%0b", mem_write));
			assert (mem_address == FLAG) else abort_run($sformatf(
				"MISMATCH test=idle mem_address expected=%0h actual=%0h", FLAG, mem_address));
		end
	endtask

	task automatic wait_flag_clear(input int t);
		bit seen;
		seen = 1'b0;
		while (!seen) begin
			@(negedge CLOCK_50);
			seen = mem_write && (mem_address == FLAG);
		end
		assert (mem_writedata == '0) else abort_run($sformatf(
			"MISMATCH test=%s flag_clear expected=%08h actual=%08h",
			test_name[t], 32'h0, mem_writedata));
	endtask

	task automatic check_frame(input int t);
		int i;
		int s;
		logic [31:0] exp_word;
		boids_mem_pkg::mem_word_t got;
		ram_i.peek_word(FLAG, got);
		assert (got == '0) else abort_run($sformatf(
			"MISMATCH test=%s flag expected=%08h actual=%08h", test_name[t], 32'h0, got));
		for (i = 0; i < NB; i++) begin
			for (s = 0; s < 4; s++) begin
				// Sign extended 27 bit value is the plain 32 bit integer
				exp_word = expect_v[t][i][s];
				ram_i.peek_word(word_addr(i, s), got);
				assert (got == exp_word) else abort_run($sformatf(
					"MISMATCH test=%s boid=%0d word=%s expected=%08h actual=%08h",
					test_name[t], i, slot_label(s), exp_word, got));
			end
		end
	endtask

	task automatic check_quiet(input int t);
		repeat (QUIET_CYCLES) begin
			@(negedge CLOCK_50);
			assert (!mem_write) else abort_run($sformatf(
				"MISMATCH test=%s write_after_clear expected=0 actual=%0b",
				test_name[t], mem_write));
		end
	endtask

	task automatic apply_test(input int t);
		int i;
		int s;
		@(posedge CLOCK_50);
		#DRIVE_DELAY;
		if (test_reload[t]) begin
			for (i = 0; i < NB; i++) begin
				for (s = 0; s < 4; s++) begin
					ram_i.poke_word(word_addr(i, s), stim[t][i][s] & ATTR_MASK);
				end
			end
		end
		ram_i.poke_word(FLAG, test_flag[t]);
		wait_flag_clear(t);
		// Let the clear land in the RAM
		@(posedge CLOCK_50);
		#DRIVE_DELAY;
		check_frame(t);
		check_quiet(t);
	endtask

	initial begin
		int t;
		seed = 46;
		sys_reset = 1'b1;
		build_table();
		@(posedge CLOCK_50);
		#DRIVE_DELAY;
		ram_i.poke_word(FLAG, '0);
		repeat (RESET_CYCLES - 1) @(posedge CLOCK_50);
		#DRIVE_DELAY;
		sys_reset = 1'b0;
		check_idle();
		for (t = 0; t < NUM_TESTS; t++) begin
			apply_test(t);
		end
		$display("ALL TESTS PASSED");
		$finish;
	end

endmodule

`default_nettype wire

//--- build.f
+incdir+.
boids_mem_pkg.sv
boids_state_pkg.sv
boid_store.sv
boid_motion_step.sv
boid_frame_sequencer.sv
boids_engine_top.sv
tb_onchip_ram.sv
boids_engine_tb.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the boid engine testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
	-f build.f --top-module boids_engine_tb \
	--Mdir obj_dir -o boids_sim

# The run decides pass or fail by its own report
sim_out="$(./obj_dir/boids_sim 2>&1)" || true
printf '%s\n' "$sim_out"
printf '%s\n' "$sim_out" | grep -q "ALL TESTS PASSED"
